/* hw/adc_sample_banks.sv */
// two adc sample registers written in turn on the read strobe
// also remembers which bank holds the latest sample
`default_nettype none

module adc_sample_banks
  import ugb_pkg::*;
(
  input  wire logic      ugb_clock,
  input  wire logic      ugb_reset,
  input  wire logic      adc_rd_en,
  input  wire logic      adc_bus_bank_select,
  input  wire adc_word_t adc_data,
  output adc_word_t      bank_0,
  output adc_word_t      bank_1,
  output logic           newer_bank
);

  always_ff @(posedge ugb_clock) begin
    if (ugb_reset) begin
      bank_0     <= '0;
      bank_1     <= '0;
      newer_bank <= 1'b1;                          // so the first read into bank 0 is newest
    end else if (adc_rd_en) begin
      if (adc_bus_bank_select) begin
        bank_1 <= adc_data;
      end else begin
        bank_0 <= adc_data;
      end
      newer_bank <= adc_bus_bank_select;           // last written bank is the newer one
    end
  end

endmodule

`default_nettype wire

/* hw/gear_shifter.sv */
// byte window selection of the gearbox
// joins the two sample banks into one bit stream and registers a byte per gear step
`default_nettype none

module gear_shifter
  import ugb_pkg::*;
#(
  parameter gear_t reset_gear = RESET_GEAR
) (
  input  wire logic      ugb_clock,
  input  wire logic      ugb_reset,
  input  wire logic      ugb_enable,
  input  wire gear_t     gear_select,
  input  wire adc_word_t bank_0,
  input  wire adc_word_t bank_1,
  input  wire logic      newer_bank,
  output byte_t          out_byte,
  output logic           out_valid
);

  localparam int STREAM_BITS = 2 * $bits(adc_word_t);
  localparam int BYTE_BITS   = $bits(byte_t);

  logic [STREAM_BITS-1:0] stream;
  gear_t                  byte_gear;
  logic [4:0]             window_start;
  byte_t                  window_byte;
  logic                   primed;

  // The banks only hold a gear's sample after the cycle that read it, so
  // the byte sent in this cycle belongs to the previous gear position.
  // Gear and banks only move on enabled cycles, so one step back is exact.
  always_comb begin
    if (gear_select == '0) begin
      byte_gear = gear_t'(GEAR_COUNT - 1);
    end else begin
      byte_gear = gear_select - 1'b1;
    end
  end

  // older sample in the low half, newer sample on top
  always_comb begin
    if (newer_bank) begin
      stream = {bank_1, bank_0};
    end else begin
      stream = {bank_0, bank_1};
    end
  end

  // the newest unsent bit sits at the top, so the window starts
  // residue plus one byte below the top of the stream
  always_comb begin
    window_start = 5'(STREAM_BITS - BYTE_BITS - gear_residue(byte_gear));
    window_byte  = stream[window_start +: BYTE_BITS];
  end

  always_ff @(posedge ugb_clock) begin
    if (ugb_reset) begin
      primed    <= 1'b0;
      out_byte  <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= ugb_enable & primed;            // drops on any held cycle
      if (ugb_enable) begin
        if (gear_select != reset_gear) begin
          primed <= 1'b1;                          // first step after reset reads the first sample
        end
        if (primed) begin
          out_byte <= window_byte;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hw/ugb_pkg.sv */
// shared definitions for the unbuffered 13-to-8 gearbox
// sample and byte widths, gear positions and the state encoding
`default_nettype none

package ugb_pkg;

  typedef logic [12:0] adc_word_t;                 // one adc sample
  typedef logic [7:0]  byte_t;                     // one output byte
  typedef logic [3:0]  gear_t;                     // gear position 0 to 12

  localparam int    GEAR_COUNT = 13;               // positions per full turn
  localparam gear_t RESET_GEAR = 4'd12;            // position with residue 0

  // encoding is {bank_select, adc_rd_en, gear}
  // the name gives bits read, then residue left after the byte goes out
  typedef enum logic [5:0] {
    STATE_13_IN_05_RESIDUE = 6'b0_1_0000,
    STATE_13_IN_10_RESIDUE = 6'b1_1_0001,
    STATE_00_IN_02_RESIDUE = 6'b0_0_0010,
    STATE_13_IN_07_RESIDUE = 6'b0_1_0011,
    STATE_13_IN_12_RESIDUE = 6'b1_1_0100,
    STATE_00_IN_04_RESIDUE = 6'b0_0_0101,
    STATE_13_IN_09_RESIDUE = 6'b0_1_0110,
    STATE_00_IN_01_RESIDUE = 6'b1_0_0111,
    STATE_13_IN_06_RESIDUE = 6'b1_1_1000,
    STATE_13_IN_11_RESIDUE = 6'b0_1_1001,
    STATE_00_IN_03_RESIDUE = 6'b1_0_1010,
    STATE_13_IN_08_RESIDUE = 6'b1_1_1011,
    STATE_00_IN_00_RESIDUE = 6'b0_0_1100
  } ugb_state_e;

  // unsent bits left over once the byte of this gear position is sent
  function automatic int unsigned gear_residue(gear_t gear);
    case (gear)
      4'd0:    return 5;
      4'd1:    return 10;
      4'd2:    return 2;
      4'd3:    return 7;
      4'd4:    return 12;
      4'd5:    return 4;
      4'd6:    return 9;
      4'd7:    return 1;
      4'd8:    return 6;
      4'd9:    return 11;
      4'd10:   return 3;
      4'd11:   return 8;
      default: return 0;                           // gear 12 and unused codes
    endcase
  endfunction

endpackage

`default_nettype wire

/* hw/unbuffered_gear_box.sv */
// top level of the unbuffered 13-to-8 gearbox
// gear state machine, sample banks and byte shifter
`default_nettype none

module unbuffered_gear_box
  import ugb_pkg::*;
#(
  parameter gear_t reset_gear = RESET_GEAR
) (
  input  wire logic      ugb_clock,
  input  wire logic      ugb_reset,
  input  wire logic      ugb_enable,
  input  wire adc_word_t adc_data,
  output logic           adc_rd_en,
  output byte_t          out_byte,
  output logic           out_valid
);

  logic      adc_bus_bank_select;
  gear_t     gear_select;
  adc_word_t bank_0;
  adc_word_t bank_1;
  logic      newer_bank;

  unbuffered_gear_box_fsm #(
    .reset_gear (reset_gear)
  ) unbuffered_gear_box_fsm_inst (
    .ugb_clock           (ugb_clock),
    .ugb_reset           (ugb_reset),
    .ugb_enable          (ugb_enable),
    .adc_bus_bank_select (adc_bus_bank_select),
    .adc_rd_en           (adc_rd_en),
    .gear_select         (gear_select)
  );

  adc_sample_banks adc_sample_banks_inst (
    .ugb_clock           (ugb_clock),
    .ugb_reset           (ugb_reset),
    .adc_rd_en           (adc_rd_en),
    .adc_bus_bank_select (adc_bus_bank_select),
    .adc_data            (adc_data),
    .bank_0              (bank_0),
    .bank_1              (bank_1),
    .newer_bank          (newer_bank)
  );

  gear_shifter #(
    .reset_gear (reset_gear)
  ) gear_shifter_inst (
    .ugb_clock   (ugb_clock),
    .ugb_reset   (ugb_reset),
    .ugb_enable  (ugb_enable),
    .gear_select (gear_select),
    .bank_0      (bank_0),
    .bank_1      (bank_1),
    .newer_bank  (newer_bank),
    .out_byte    (out_byte),
    .out_valid   (out_valid)
  );

endmodule

`default_nettype wire

/* hw/unbuffered_gear_box_fsm.sv */
// gear state machine of the unbuffered gearbox
// steps through 13 positions, 8 sample reads and 13 bytes per turn
`default_nettype none

module unbuffered_gear_box_fsm
  import ugb_pkg::*;
#(
  parameter gear_t reset_gear = RESET_GEAR
) (
  input  wire logic  ugb_clock,
  input  wire logic  ugb_reset,
  input  wire logic  ugb_enable,
  output logic       adc_bus_bank_select,
  output logic       adc_rd_en,
  output gear_t      gear_select
);

  // state that carries a given gear in its low field
  function automatic ugb_state_e state_of_gear(gear_t gear);
    case (gear)
      4'd0:    return STATE_13_IN_05_RESIDUE;
      4'd1:    return STATE_13_IN_10_RESIDUE;
      4'd2:    return STATE_00_IN_02_RESIDUE;
      4'd3:    return STATE_13_IN_07_RESIDUE;
      4'd4:    return STATE_13_IN_12_RESIDUE;
      4'd5:    return STATE_00_IN_04_RESIDUE;
      4'd6:    return STATE_13_IN_09_RESIDUE;
      4'd7:    return STATE_00_IN_01_RESIDUE;
      4'd8:    return STATE_13_IN_06_RESIDUE;
      4'd9:    return STATE_13_IN_11_RESIDUE;
      4'd10:   return STATE_00_IN_03_RESIDUE;
      4'd11:   return STATE_13_IN_08_RESIDUE;
      default: return STATE_00_IN_00_RESIDUE;
    endcase
  endfunction

  localparam ugb_state_e reset_state = state_of_gear(reset_gear);

  ugb_state_e state;
  ugb_state_e next_state;

  always_ff @(posedge ugb_clock) begin
    if (ugb_reset) begin
      state <= reset_state;
    end else begin
      state <= next_state;
    end
  end

  // each enabled cycle moves one position, a low enable holds
  always_comb begin
    next_state = reset_state;                      // undefined codes recover here
    case (state)
      STATE_13_IN_05_RESIDUE:
        next_state = ugb_enable ? STATE_13_IN_10_RESIDUE : state;
      STATE_13_IN_10_RESIDUE:
        next_state = ugb_enable ? STATE_00_IN_02_RESIDUE : state;
      STATE_00_IN_02_RESIDUE:
        next_state = ugb_enable ? STATE_13_IN_07_RESIDUE : state;
      STATE_13_IN_07_RESIDUE:
        next_state = ugb_enable ? STATE_13_IN_12_RESIDUE : state;
      STATE_13_IN_12_RESIDUE:
        next_state = ugb_enable ? STATE_00_IN_04_RESIDUE : state;
      STATE_00_IN_04_RESIDUE:
        next_state = ugb_enable ? STATE_13_IN_09_RESIDUE : state;
      STATE_13_IN_09_RESIDUE:
        next_state = ugb_enable ? STATE_00_IN_01_RESIDUE : state;
      STATE_00_IN_01_RESIDUE:
        next_state = ugb_enable ? STATE_13_IN_06_RESIDUE : state;
      STATE_13_IN_06_RESIDUE:
        next_state = ugb_enable ? STATE_13_IN_11_RESIDUE : state;
      STATE_13_IN_11_RESIDUE:
        next_state = ugb_enable ? STATE_00_IN_03_RESIDUE : state;
      STATE_00_IN_03_RESIDUE:
        next_state = ugb_enable ? STATE_13_IN_08_RESIDUE : state;
      STATE_13_IN_08_RESIDUE:
        next_state = ugb_enable ? STATE_00_IN_00_RESIDUE : state;
      STATE_00_IN_00_RESIDUE:
        next_state = ugb_enable ? STATE_13_IN_05_RESIDUE : state;
      default:
        next_state = reset_state;
    endcase
  end

  // outputs come straight from the encoding fields
  assign gear_select         = state[3:0];
  assign adc_rd_en           = state[4] & ugb_enable; // a held gearbox takes no sample
  assign adc_bus_bank_select = state[5];

endmodule

`default_nettype wire

/* list.f */
hw/ugb_pkg.sv
hw/unbuffered_gear_box_fsm.sv
hw/adc_sample_banks.sv
hw/gear_shifter.sv
hw/unbuffered_gear_box.sv
test/tb_unbuffered_gear_box.sv

/* test/tb_unbuffered_gear_box.sv */
// testbench for the unbuffered 13-to-8 gearbox
// random adc source, bit queue reference model and a comparing process
`default_nettype none

module tb_unbuffered_gear_box
  import ugb_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int IDLE_CYCLES        = 20;
  localparam int STEADY_CYCLES      = GEAR_COUNT * 20;
  localparam int RANDOM_CYCLES      = GEAR_COUNT * 30;
  localparam int FIRST_BYTE_TIMEOUT = 8;           // enabled cycles allowed before the first byte
  localparam int DRAIN_TIMEOUT      = 4;
  localparam int MAX_QUEUED_BITS    = 13 + 8;

  logic      ugb_clock;
  logic      ugb_reset;
  logic      ugb_enable;
  adc_word_t adc_data;
  logic      adc_rd_en;
  byte_t     out_byte;
  logic      out_valid;

  logic [31:0]           rng_state;
  bit                    bit_queue[$];             // unsent sample bits in arrival order
  logic [GEAR_COUNT-1:0] read_history;             // read strobes of the last enabled cycles
  logic                  prev_enable;
  byte_t                 expected;
  int                    error_count;
  int                    bytes_checked;
  int                    read_count;
  int                    enabled_count;
  int                    steps_used;
  int                    drain_steps;
  bit                    first_seen;

  unbuffered_gear_box #(
    .reset_gear (RESET_GEAR)
  ) unbuffered_gear_box_inst (
    .ugb_clock  (ugb_clock),
    .ugb_reset  (ugb_reset),
    .ugb_enable (ugb_enable),
    .adc_data   (adc_data),
    .adc_rd_en  (adc_rd_en),
    .out_byte   (out_byte),
    .out_valid  (out_valid)
  );

  always #2 ugb_clock = ~ugb_clock;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // expected byte with the earliest queued bit in bit 0
  function automatic byte_t reference_byte();
    byte_t b;
    for (int i = 0; i < $bits(byte_t); i++) begin
      b[i] = bit_queue.pop_front();
    end
    return b;
  endfunction

  function automatic int count_reads(input logic [GEAR_COUNT-1:0] window);
    int n;
    n = 0;
    for (int i = 0; i < GEAR_COUNT; i++) begin
      n = n + int'(window[i]);
    end
    return n;
  endfunction

  task automatic push_sample(input adc_word_t sample);
    for (int i = 0; i < $bits(adc_word_t); i++) begin
      bit_queue.push_back(sample[i]);                // lsb goes out first
    end
  endtask

  task automatic step_cycle();
    @(posedge ugb_clock);
    #0.5;
  endtask

  // a fresh sample every cycle but only the read ones enter the reference
  task automatic drive_inputs(input logic enable);
    rng_state  = xorshift32(rng_state);
    adc_data   = adc_word_t'(rng_state[12:0]);
    ugb_enable = enable;
  endtask

  // sampled on the falling edge where every dut output has settled
  always @(negedge ugb_clock) begin
    if (!ugb_reset) begin
      if (out_valid) begin
        assert (bit_queue.size() >= $bits(byte_t)) else begin
          error_count++;
          $display("byte sent at %0.1f ns before enough sample bits were read", $realtime);
        end
        if (bit_queue.size() >= $bits(byte_t)) begin
          expected = reference_byte();
          bytes_checked++;
          assert (out_byte === expected) else begin
            error_count++;
            $display("Error at %0.1f ns: out_byte expected 0x%02h, got 0x%02h",
                     $realtime, expected, out_byte);
          end
        end
      end
      if (adc_rd_en) begin
        push_sample(adc_data);
        read_count++;
      end
      if (ugb_enable) begin
        read_history = {read_history[GEAR_COUNT-2:0], adc_rd_en};
        if (enabled_count < GEAR_COUNT) begin
          enabled_count++;
        end
        if (enabled_count == GEAR_COUNT) begin
          assert (count_reads(read_history) == 8) else begin
            error_count++;
            $display("Error at %0.1f ns: adc_rd_en count over 13 cycles expected 8, got %0d",
                     $realtime, count_reads(read_history));
          end
        end
      end else begin
        assert (adc_rd_en == 1'b0) else begin
          error_count++;
          $display("Error at %0.1f ns: adc_rd_en expected 0, got %b", $realtime, adc_rd_en);
        end
      end
      if (!prev_enable) begin
        assert (out_valid == 1'b0) else begin
          error_count++;
          $display("Error at %0.1f ns: out_valid expected 0, got %b", $realtime, out_valid);
        end
      end
      prev_enable = ugb_enable;
    end
  end

  initial begin
    ugb_clock     = 1'b0;
    ugb_reset     = 1'b1;
    ugb_enable    = 1'b0;
    adc_data      = '0;
    rng_state     = 32'd51314;
    read_history  = '0;
    prev_enable   = 1'b0;
    error_count   = 0;
    bytes_checked = 0;
    read_count    = 0;
    enabled_count = 0;
    first_seen    = 1'b0;

    repeat (10) @(posedge ugb_clock);
    #0.5;
    ugb_reset = 1'b0;

    // held gearbox right after reset
    for (int n = 0; n < IDLE_CYCLES; n++) begin
      drive_inputs(1'b0);
      step_cycle();
    end

    // steady enable where the first byte must show up within a few steps
    steps_used = 0;
    while (!first_seen && steps_used < FIRST_BYTE_TIMEOUT) begin
      drive_inputs(1'b1);
      step_cycle();
      steps_used++;
      first_seen = out_valid;
    end
    if (!first_seen) begin
      error_count++;
      $display("no output byte within %0d enabled cycles", FIRST_BYTE_TIMEOUT);
    end
    for (int n = steps_used; n < STEADY_CYCLES; n++) begin
      drive_inputs(1'b1);
      step_cycle();
    end

    // enable toggled at random
    for (int n = 0; n < RANDOM_CYCLES; n++) begin
      rng_state = xorshift32(rng_state);
      drive_inputs(rng_state[5]);
      step_cycle();
    end

    // hold and let the last byte out
    drive_inputs(1'b0);
    step_cycle();
    drain_steps = 0;
    while (out_valid && drain_steps < DRAIN_TIMEOUT) begin
      step_cycle();
      drain_steps++;
    end
    if (out_valid) begin
      error_count++;
      $display("out_valid still high %0d cycles after the gearbox was held", DRAIN_TIMEOUT);
    end
    step_cycle();

    assert (bit_queue.size() < MAX_QUEUED_BITS) else begin
      error_count++;
      $display("%0d sample bits were never sent, bytes were lost", bit_queue.size());
    end
    assert (bytes_checked > 0) else begin
      error_count++;
      $display("the gearbox sent no bytes at all");
    end

    $display("errors: %0d, bytes checked: %0d, samples read: %0d, bits left: %0d",
             error_count, bytes_checked, read_count, bit_queue.size());
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // backstop against a stuck run
  initial begin
    #20000;
    $display("simulation did not finish in time");
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire
